// File: verif/player_move_input.txt
# w <tile addr> <tile code> | m <dir 0 none 1 up 2 down 3 left 4 right> <ticks> | e <x> <y>
# Tile addr is row*19+col in decimal, e gives the expected screen position after the moves
m 1 2
m 3 2
e 96 160
m 2 4
e 96 176
w 58 2
m 2 16
e 96 240
m 2 2
e 96 240
m 0 3
e 96 240
m 4 7
e 124 240
m 4 1
e 128 240
m 4 1
e 128 240
m 1 1
e 128 236

// File: all.f
+incdir+logic
logic/bomber_pkg.sv
logic/obst_if.sv
logic/tile_map_ram.sv
logic/check_obst.sv
logic/player_controller.sv
logic/player_move_top.sv
verif/player_move_props.sv
verif/player_move_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module player_move_tb -f all.f -o player_move_sim &&
  ./obj_dir/player_move_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
  echo "Simulation run succeeded" ||
  { echo "Simulation run failed"; exit 1; }

// File: verif/player_move_tb.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

module player_move_tb;

  localparam int TICK_GAP = 24;  // Cycles from one tick to the next
  localparam int TIMEOUT  = 200; // Cycle limit of each wait
  localparam int START_X  = 96;  // Reset position on screen
  localparam int START_Y  = 160;

  logic                   clk;
  logic                   rst;
  logic                   tick;
  bomber_pkg::dir_t       move_dir;
  logic                   wr_en;
  logic [`MAP_ADDR_W-1:0] wr_addr;
  bomber_pkg::tile_t      wr_data;
  logic [10:0]            player_x; // Screen pixels
  logic [9:0]             player_y;

  int    fd;
  int    n_fields;
  int    arg_a;
  int    arg_b;
  int    n_checks;
  byte   kind; // Command letter of a file line
  string line;

  player_move_top player_move_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Drive point just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic stop_on_error();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Border walls and pillars where row and column are both even
  function automatic bomber_pkg::tile_t maze_tile(input int row, input int col);
    if (row == 0 || row == `NUM_ROW - 1 || col == 0 || col == `NUM_COL - 1)
      return bomber_pkg::TILE_PERM;
    if ((row % 2 == 0) && (col % 2 == 0))
      return bomber_pkg::TILE_PERM;
    return bomber_pkg::TILE_FREE;
  endfunction

  // Waits for end-of-scan pulses plus one cycle for the controller latch
  task automatic wait_reports(input int count, output int used);
    int seen;
    seen = 0;
    used = 0;
    while (seen < count) begin
      next_cycle();
      used++;
      if (player_move_top_i.obst_bus.obstacles_valid)
        seen++;
      assert (used < TIMEOUT) else begin
        $display("Timeout: no obstacle report within %0d cycles", TIMEOUT);
        stop_on_error();
      end
    end
    next_cycle();
    used++;
  endtask

  task automatic write_tile(input int addr, input int code);
    wr_en   = 1'b1;
    wr_addr = `MAP_ADDR_W'(addr);
    wr_data = bomber_pkg::tile_t'(code);
    next_cycle();
    wr_en   = 1'b0;
  endtask

  task automatic run_ticks(input int dir_code, input int count);
    int used;
    int k;
    for (k = 0; k < count; k++) begin
      tick     = 1'b1;
      move_dir = bomber_pkg::dir_t'(dir_code);
      next_cycle(); // Move happens on this edge
      tick     = 1'b0;
      move_dir = bomber_pkg::DIR_NONE;
      wait_reports(2, used); // Second report is of the new position
      while (used < TICK_GAP - 1) begin
        next_cycle();
        used++;
      end
    end
  endtask

  task automatic check_position(input int exp_x, input int exp_y);
    assert (player_x == 11'(exp_x)) else begin
      $display("** Error at %0t: player_x expected %0d, got %0d", $time, exp_x, player_x);
      stop_on_error();
    end
    assert (player_y == 10'(exp_y)) else begin
      $display("** Error at %0t: player_y expected %0d, got %0d", $time, exp_y, player_y);
      stop_on_error();
    end
    n_checks++;
  endtask

  initial begin
    int used;
    int row;
    int col;
    rst      = 1'b1;
    tick     = 1'b0;
    move_dir = bomber_pkg::DIR_NONE;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = bomber_pkg::TILE_FREE;
    n_checks = 0;
    repeat (3) next_cycle();
    rst = 1'b0;
    check_position(START_X, START_Y); // Before any tick

    for (row = 0; row < `NUM_ROW; row++) begin
      for (col = 0; col < `NUM_COL; col++) begin
        write_tile(row * `NUM_COL + col, int'(maze_tile(row, col)));
      end
    end
    wait_reports(2, used); // First report of the loaded maze

    fd = $fopen("verif/player_move_input.txt", "r");
    assert (fd != 0) else begin
      $display("Cannot open verif/player_move_input.txt");
      stop_on_error();
    end
    while ($fgets(line, fd) != 0) begin
      n_fields = $sscanf(line, "%c %d %d", kind, arg_a, arg_b);
      if (n_fields == 3) begin // Comments and blank lines fall through
        case (kind)
          "w": begin
            write_tile(arg_a, arg_b);
            wait_reports(2, used); // Brick is in the latched report
          end
          "m": run_ticks(arg_a, arg_b);
          "e": check_position(arg_a, arg_b);
          default: begin
            $display("Unknown command in the input file: %s", line);
            stop_on_error();
          end
        endcase
      end
    end
    $fclose(fd);

    if (n_checks > 1) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("No expected positions were read from the input file");
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verif/player_move_props.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

module player_move_props (
  input logic             clk,
  input logic             rst,
  input logic             tick,
  input bomber_pkg::dir_t move_dir,
  input logic [3:0]       obst,     // Latched zero-distance flags
  input logic [10:0]      player_x,
  input logic [9:0]       player_y
);

  logic [10:0] prev_x; // Position one cycle back
  logic [9:0]  prev_y;
  logic [10:0] step_x;
  logic [9:0]  step_y;
  logic        blocked_move;

  always_ff @(posedge clk) begin
    prev_x <= player_x;
    prev_y <= player_y;
  end

  assign step_x = (player_x >= prev_x) ? player_x - prev_x : prev_x - player_x;
  assign step_y = (player_y >= prev_y) ? player_y - prev_y : prev_y - player_y;

  // Tick toward a direction flagged as touching an obstacle
  assign blocked_move = tick && (
    (move_dir == bomber_pkg::DIR_UP    && obst[bomber_pkg::UP])   ||
    (move_dir == bomber_pkg::DIR_DOWN  && obst[bomber_pkg::DOWN]) ||
    (move_dir == bomber_pkg::DIR_LEFT  && obst[bomber_pkg::LEFT]) ||
    (move_dir == bomber_pkg::DIR_RIGHT && obst[bomber_pkg::RIGHT]));

  hold_without_tick: assert property (@(posedge clk) disable iff (rst)
    !tick |=> $stable(player_x) && $stable(player_y))
    else $error("Position changed without a tick");

  hold_when_blocked: assert property (@(posedge clk) disable iff (rst)
    blocked_move |=> $stable(player_x) && $stable(player_y))
    else $error("Position changed toward a blocked direction");

  step_bounded: assert property (@(posedge clk) disable iff (rst)
    tick |=> (step_x <= 11'(`STEP_SIZE)) && (step_y <= 10'(`STEP_SIZE)))
    else $error("Single move larger than one step");

endmodule

bind player_controller player_move_props player_move_props_i (
  .clk      (clk),
  .rst      (rst),
  .tick     (tick),
  .move_dir (move_dir),
  .obst     (obst_r),
  .player_x (player_x),
  .player_y (player_y)
);

// File: logic/player_move_top.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

module player_move_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  bomber_pkg::dir_t       move_dir,
  input  logic                   wr_en,
  input  logic [`MAP_ADDR_W-1:0] wr_addr,
  input  bomber_pkg::tile_t      wr_data,
  output logic [10:0]            player_x,
  output logic [9:0]             player_y
);

  logic [`MAP_ADDR_W-1:0] rd_addr; // Checker to RAM
  bomber_pkg::tile_t      rd_data;
  logic [10:0]            map_x;   // Controller back to checker
  logic [9:0]             map_y;

  obst_if obst_bus ();

  tile_map_ram map_ram_i (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  check_obst check_obst_i (
    .clk     (clk),
    .rst     (rst),
    .map_x   (map_x),
    .map_y   (map_y),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rep     (obst_bus.producer)
  );

  player_controller player_controller_i (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .move_dir (move_dir),
    .rep      (obst_bus.consumer),
    .map_x    (map_x),
    .map_y    (map_y),
    .player_x (player_x),
    .player_y (player_y)
  );

endmodule

// File: logic/player_controller.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

module player_controller (
  input  logic              clk,
  input  logic              rst,
  input  logic              tick,
  input  bomber_pkg::dir_t  move_dir,
  obst_if.consumer          rep,
  output logic [10:0]       map_x,
  output logic [9:0]        map_y,
  output logic [10:0]       player_x, // Screen pixels
  output logic [9:0]        player_y
);

  localparam logic [`DIST_W-1:0] STEP_REQ = `DIST_W'(`STEP_SIZE); // Full step

  logic [3:0]         obst_r;
  logic [`DIST_W-1:0] dist_r [4];
  logic [`DIST_W-1:0] step   [4];

  // Screen to map with a clamp into the first free tile
  assign map_x = (player_x > 11'(`HUD_SIDE_PX)) ? player_x - 11'(`HUD_SIDE_PX)
                                                : 11'(`TILE_PX);
  assign map_y = (player_y > 10'(`HUD_TOP_PX)) ? player_y - 10'(`HUD_TOP_PX)
                                               : 10'(`TILE_PX);

  // Hold the last complete report
  always_ff @(posedge clk) begin
    if (rst) begin
      obst_r <= '0;
      for (int d = 0; d < 4; d++) begin
        dist_r[d] <= '1;
      end
    end else if (rep.obstacles_valid) begin
      obst_r <= rep.obstacles;
      for (int d = 0; d < 4; d++) begin
        dist_r[d] <= rep.obstacle_dist[d];
      end
    end
  end

  // Saturated step per direction
  always_comb begin
    for (int d = 0; d < 4; d++) begin
      if (obst_r[d]) begin
        step[d] = '0;
      end else begin
        step[d] = (dist_r[d] < STEP_REQ) ? dist_r[d] : STEP_REQ;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      player_x <= 11'(`INIT_X + `HUD_SIDE_PX);
      player_y <= 10'(`INIT_Y + `HUD_TOP_PX);
    end else if (tick) begin
      case (move_dir)
        bomber_pkg::DIR_UP:    player_y <= player_y - 10'(step[bomber_pkg::UP]);
        bomber_pkg::DIR_DOWN:  player_y <= player_y + 10'(step[bomber_pkg::DOWN]);
        bomber_pkg::DIR_LEFT:  player_x <= player_x - 11'(step[bomber_pkg::LEFT]);
        bomber_pkg::DIR_RIGHT: player_x <= player_x + 11'(step[bomber_pkg::RIGHT]);
        default: ; // DIR_NONE holds position
      endcase
    end
  end

endmodule

// File: logic/check_obst.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

module check_obst (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [10:0]            map_x,
  input  logic [9:0]             map_y,
  output logic [`MAP_ADDR_W-1:0] rd_addr,
  input  bomber_pkg::tile_t      rd_data,
  obst_if.producer               rep
);

  localparam logic [3:0] SCAN_LAST = 4'd9; // Report cycle, scan is 10 cycles

  logic [3:0]          cnt;         // Scan cycle
  logic [10:0]         px_r;        // Position sampled on cycle 0
  logic [9:0]          py_r;
  logic [10:0]         cur_x;
  logic [9:0]          cur_y;
  logic [11:0]         e_up, e_down, e_left, e_right; // Sprite edges
  logic [5:0]          row_up, row_down, col_left, col_right;
  logic [5:0]          col_a, col_b, row_a, row_b; // Side tiles covered by the sprite
  logic [5:0]          probe_row, probe_col;
  logic [7:0]          blk_r;       // Blocked flag per probe
  logic [3:0]          blocked;
  logic [`DIST_W-1:0]  dist_blk [4];

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt <= (cnt == SCAN_LAST) ? 4'd0 : cnt + 4'd1;
    end
  end

  // Sample the position at scan start
  always_ff @(posedge clk) begin
    if (cnt == 4'd0) begin
      px_r <= map_x;
      py_r <= map_y;
    end
  end

  // Cycle 0 probes straight from the inputs
  assign cur_x = (cnt == 4'd0) ? map_x : px_r;
  assign cur_y = (cnt == 4'd0) ? map_y : py_r;

  assign e_up    = 12'(cur_y);
  assign e_down  = 12'(cur_y) + 12'(`SPRITE_H);
  assign e_left  = 12'(cur_x);
  assign e_right = 12'(cur_x) + 12'(`SPRITE_W);

  // Tile just past each edge
  assign row_up    = 6'((e_up - 12'd1) >> `TILE_SHIFT);
  assign row_down  = 6'(e_down >> `TILE_SHIFT);
  assign col_left  = 6'((e_left - 12'd1) >> `TILE_SHIFT);
  assign col_right = 6'(e_right >> `TILE_SHIFT);

  assign col_a = 6'(e_left >> `TILE_SHIFT);
  assign col_b = 6'((e_left + 12'(`SPRITE_W - 1)) >> `TILE_SHIFT);
  assign row_a = 6'(e_up >> `TILE_SHIFT);
  assign row_b = 6'((e_up + 12'(`SPRITE_H - 1)) >> `TILE_SHIFT);

  // Two probes per direction, cnt[2:1] is the direction index
  always_comb begin
    probe_row = row_up;
    probe_col = col_a;
    case (int'(cnt[2:1]))
      bomber_pkg::UP: begin
        probe_row = row_up;
        probe_col = cnt[0] ? col_b : col_a;
      end
      bomber_pkg::DOWN: begin
        probe_row = row_down;
        probe_col = cnt[0] ? col_b : col_a;
      end
      bomber_pkg::LEFT: begin
        probe_col = col_left;
        probe_row = cnt[0] ? row_b : row_a;
      end
      default: begin
        probe_col = col_right;
        probe_row = cnt[0] ? row_b : row_a;
      end
    endcase
  end

  assign rd_addr = `MAP_ADDR_W'(probe_row * `NUM_COL + probe_col);

  // Data for probe n lands on cycle n+1
  always_ff @(posedge clk) begin
    if ((cnt != 4'd0) && (cnt != SCAN_LAST)) begin
      blk_r[cnt[2:0] - 3'd1] <= (rd_data != bomber_pkg::TILE_FREE);
    end
  end

  // Gap from each edge to the probed tile
  assign dist_blk[bomber_pkg::UP] =
    `DIST_W'(e_up - ((12'(row_up) + 12'd1) << `TILE_SHIFT));
  assign dist_blk[bomber_pkg::DOWN] =
    `DIST_W'((12'(row_down) << `TILE_SHIFT) - e_down);
  assign dist_blk[bomber_pkg::LEFT] =
    `DIST_W'(e_left - ((12'(col_left) + 12'd1) << `TILE_SHIFT));
  assign dist_blk[bomber_pkg::RIGHT] =
    `DIST_W'((12'(col_right) << `TILE_SHIFT) - e_right);

  always_comb begin
    for (int d = 0; d < 4; d++) begin
      blocked[d] = blk_r[2*d] | blk_r[2*d+1]; // Either side tile blocks
      rep.obstacle_dist[d] = blocked[d] ? dist_blk[d] : `DIST_W'(`TILE_PX);
      rep.obstacles[d] = blocked[d] && (dist_blk[d] == '0);
    end
  end

  assign rep.obstacles_valid = (cnt == SCAN_LAST);

endmodule

// File: logic/tile_map_ram.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

module tile_map_ram (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_en,
  input  logic [`MAP_ADDR_W-1:0]   wr_addr,
  input  bomber_pkg::tile_t        wr_data,
  input  logic [`MAP_ADDR_W-1:0]   rd_addr,
  output bomber_pkg::tile_t        rd_data
);

  localparam int DEPTH = `NUM_ROW * `NUM_COL; // 209 tiles

  bomber_pkg::tile_t mem [DEPTH];

  // Write port, addresses past the map are dropped
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr < DEPTH)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, one cycle of latency
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= bomber_pkg::TILE_FREE;
    end else if (rd_addr < DEPTH) begin
      rd_data <= mem[rd_addr];
    end else begin
      rd_data <= bomber_pkg::TILE_PERM; // Outside the map acts as wall
    end
  end

endmodule

// File: logic/obst_if.sv
`timescale 1ns/100ps

`include "bomber_defines.svh"

// Obstacle report from the checker to the player controller
interface obst_if;

  logic [3:0]            obstacles;        // Blocked with zero distance, per direction
  logic [`DIST_W-1:0]    obstacle_dist [4]; // Free pixels per direction
  logic                  obstacles_valid;  // One-cycle pulse at end of scan

  // Checker side
  modport producer (
    output obstacles,
    output obstacle_dist,
    output obstacles_valid
  );

  // Controller side
  modport consumer (
    input obstacles,
    input obstacle_dist,
    input obstacles_valid
  );

endinterface

// File: logic/bomber_pkg.sv
package bomber_pkg;

  // Requested move
  typedef enum logic [2:0] {
    DIR_NONE  = 3'd0,
    DIR_UP    = 3'd1,
    DIR_DOWN  = 3'd2,
    DIR_LEFT  = 3'd3,
    DIR_RIGHT = 3'd4
  } dir_t;

  // Tile codes, anything but TILE_FREE blocks the player
  typedef enum logic [1:0] {
    TILE_FREE  = 2'd0,
    TILE_PERM  = 2'd1, // Wall or pillar
    TILE_BRICK = 2'd2,
    TILE_BOMB  = 2'd3
  } tile_t;

  // Index into the 4-entry obstacle report
  localparam int UP    = 0;
  localparam int DOWN  = 1;
  localparam int LEFT  = 2;
  localparam int RIGHT = 3;

endpackage

// File: logic/bomber_defines.svh
`ifndef BOMBER_DEFINES_SVH
`define BOMBER_DEFINES_SVH

// Map size in tiles
`define NUM_ROW 11
`define NUM_COL 19

// Tile geometry, square tiles
`define TILE_PX 64
`define TILE_SHIFT 6 // log2 of TILE_PX

// Row-major tile address, row * NUM_COL + col
`define MAP_ADDR_W 8

// Player sprite, top-left corner is the position
`define SPRITE_W 32
`define SPRITE_H 48

// Pixels per tick
`define STEP_SIZE 4
`define DIST_W 7 // Holds a free distance of TILE_PX

// HUD margins around the map on the 1280x800 screen
`define HUD_SIDE_PX 32 // (1280 - 19*64) / 2
`define HUD_TOP_PX 96 // 800 - 11*64

// Start position in map pixels, first free tile
`define INIT_X 64
`define INIT_Y 64

`endif
